// ==== Makefile ====
# Verilator build and run of the iterative multiplier testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := imul_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
verilog/imul_pkg.sv
verilog/imul_ctrl.sv
verilog/imul_dpath.sv
verilog/imul_iterative.sv
testbench/imul_sva.sv
testbench/imul_tb.sv

// ==== testbench/imul_sva.sv ====
/*
 * concurrent checks on handshake, latency and back-pressure,
 * bound into the multiplier top level
 */
`default_nettype none

module imul_sva
#(
        parameter int WIDTH = imul_pkg::IMUL_WIDTH
)
(
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    req_val_i,
        input  logic                    req_rdy_o,
        input  logic [2*WIDTH-1:0]      resp_result_o,
        input  logic                    resp_val_o,
        input  logic                    resp_rdy_i
);

        logic   req_fire;               // request taken on this edge
        logic   resp_fire;              // response taken on this edge

        assign req_fire  = req_val_i && req_rdy_o;
        assign resp_fire = resp_val_o && resp_rdy_i;

        // ------------------------------------------------------------------------
        // latency from accept edge to first valid response
        // ------------------------------------------------------------------------
        a_rise_needs_accept: assert property (@(posedge clk) disable iff (reset)
                $rose(resp_val_o) |-> $past(req_fire, WIDTH + 1))
        else $error("resp_val_o rose without an accept WIDTH+1 cycles before");

        a_accept_gives_rise: assert property (@(posedge clk) disable iff (reset)
                $past(req_fire, WIDTH + 1) |-> $rose(resp_val_o))
        else $error("resp_val_o did not rise WIDTH+1 cycles after an accept");

        // ------------------------------------------------------------------------
        // back-pressure
        // ------------------------------------------------------------------------
        a_stall_holds: assert property (@(posedge clk) disable iff (reset)
                resp_val_o && !resp_rdy_i |=> resp_val_o && $stable(resp_result_o))
        else $error("response dropped or changed while downstream stalled");

        a_no_ready_in_stall: assert property (@(posedge clk) disable iff (reset)
                resp_val_o && !resp_rdy_i |=> !req_rdy_o)
        else $error("req_rdy_o rose while the downstream stalled");

        // busy window with one item in flight
        a_busy_after_accept: assert property (@(posedge clk) disable iff (reset)
                req_fire |=> !req_rdy_o)
        else $error("req_rdy_o high right after an accept");

        a_busy_holds: assert property (@(posedge clk) disable iff (reset)
                !req_rdy_o && !resp_fire |=> !req_rdy_o)
        else $error("req_rdy_o rose before the response transferred");

        a_ready_after_resp: assert property (@(posedge clk) disable iff (reset)
                resp_fire |=> req_rdy_o)
        else $error("req_rdy_o not high after the response transferred");

endmodule

bind imul_iterative imul_sva
#(
        .WIDTH          (WIDTH)
)
u_sva
(
        .clk            (clk),
        .reset          (reset),
        .req_val_i      (req_val_i),
        .req_rdy_o      (req_rdy_o),
        .resp_result_o  (resp_result_o),
        .resp_val_o     (resp_val_o),
        .resp_rdy_i     (resp_rdy_i)
);

`default_nettype wire

// ==== testbench/imul_tb.sv ====
/*
 * multiplier testbench: clock and reset, corner and lfsr operand pairs,
 * random downstream stalls, product checks against a sign-extended reference
 */
`default_nettype none

module imul_tb;

        localparam int WIDTH    = imul_pkg::IMUL_WIDTH;
        localparam int PW       = 2 * WIDTH;
        localparam int N_RANDOM = 64;           // random pairs after the corners
        localparam int TIMEOUT  = 200;          // cycles allowed per wait
        localparam logic [31:0] LFSR_SEED = 32'd1449;

        localparam logic [WIDTH-1:0] MIN_NEG = {1'b1, {(WIDTH-1){1'b0}}};
        localparam logic [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};
        localparam logic [WIDTH-1:0] ALL_ONE = '1;     // minus one

        logic                   clk;
        logic                   reset;
        logic [WIDTH-1:0]       req_a_i;
        logic [WIDTH-1:0]       req_b_i;
        logic                   req_val_i;
        logic                   req_rdy_o;
        logic [PW-1:0]          resp_result_o;
        logic                   resp_val_o;
        logic                   resp_rdy_i;

        logic [31:0]            lfsr;           // stimulus generator state

        imul_iterative
        #(
                .WIDTH          (WIDTH)
        )
        u_imul_iterative
        (
                .clk            (clk),
                .reset          (reset),
                .req_a_i        (req_a_i),
                .req_b_i        (req_b_i),
                .req_val_i      (req_val_i),
                .req_rdy_o      (req_rdy_o),
                .resp_result_o  (resp_result_o),
                .resp_val_o     (resp_val_o),
                .resp_rdy_i     (resp_rdy_i)
        );

        always #20 clk = ~clk;                  // period 40

        // ------------------------------------------------------------------------
        // stimulus source and reference model
        // ------------------------------------------------------------------------
        // galois form of x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
        endfunction

        // one lfsr step per bit taken
        task automatic draw_bits(input int n, output logic [63:0] val);
                val = '0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr = lfsr_next(lfsr);
                        val  = {val[62:0], lfsr[0]};
                end
        endtask

        function automatic logic [PW-1:0] signed_product(input logic [WIDTH-1:0] a,
                                                         input logic [WIDTH-1:0] b);
                logic signed [PW-1:0] sa;
                logic signed [PW-1:0] sb;
                sa = {{WIDTH{a[WIDTH-1]}}, a};          // sign-extend both
                sb = {{WIDTH{b[WIDTH-1]}}, b};
                signed_product = sa * sb;               // low PW bits are exact
        endfunction

        // ------------------------------------------------------------------------
        // checks and waits
        // ------------------------------------------------------------------------
        task automatic fail_run(input string why);
                $display("%s", why);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_value(input string name, input logic [PW-1:0] expected,
                                   input logic [PW-1:0] actual);
                assert (actual === expected)
                else
                begin
                        fail_run($sformatf("error: %s expected %h actual %h",
                                           name, expected, actual));
                end
        endtask

        // seen at a falling edge, taken on the next rising edge
        task automatic wait_req_ready();
                int cycles;
                cycles = 0;
                while (!req_rdy_o)
                begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > TIMEOUT)
                                fail_run("timeout: request never accepted");
                end
        endtask

        task automatic wait_resp_valid();
                int cycles;
                cycles = 0;
                while (!resp_val_o)
                begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > TIMEOUT)
                                fail_run("timeout: no response from the multiplier");
                end
        endtask

        // one full transaction with optional downstream stall
        task automatic run_pair(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
                logic [63:0]    bits;
                logic [PW-1:0]  expected;
                logic           stall;
                int             stall_len;
                expected = signed_product(a, b);
                draw_bits(1, bits);
                stall = bits[0];
                draw_bits(3, bits);
                stall_len = int'(bits[2:0]) + 1;

                @(negedge clk);
                req_a_i    = a;
                req_b_i    = b;
                req_val_i  = 1'b1;
                resp_rdy_i = !stall;
                wait_req_ready();
                @(negedge clk);                 // accepted on the edge just gone
                req_val_i = 1'b0;
                draw_bits(WIDTH, bits);
                req_a_i = bits[WIDTH-1:0];      // junk while busy
                draw_bits(WIDTH, bits);
                req_b_i = bits[WIDTH-1:0];

                wait_resp_valid();
                check_value("resp_result_o", expected, resp_result_o);
                if (stall)
                begin
                        repeat (stall_len) @(negedge clk);
                        check_value("resp_val_o", PW'(1), PW'(resp_val_o));
                        check_value("resp_result_o", expected, resp_result_o);
                        resp_rdy_i = 1'b1;      // release downstream
                end
                @(negedge clk);                 // response gone
                check_value("req_rdy_o", PW'(1), PW'(req_rdy_o));
        endtask

        // ------------------------------------------------------------------------
        // main sequence
        // ------------------------------------------------------------------------
        initial
        begin
                logic [63:0]            bits;
                logic [WIDTH-1:0]       a;
                logic [WIDTH-1:0]       b;
                clk        = 1'b0;
                reset      = 1'b1;
                req_a_i    = '0;
                req_b_i    = '0;
                req_val_i  = 1'b0;
                resp_rdy_i = 1'b0;
                lfsr       = LFSR_SEED;

                repeat (16) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                @(negedge clk);
                check_value("resp_val_o", PW'(0), PW'(resp_val_o));
                check_value("req_rdy_o", PW'(1), PW'(req_rdy_o));

                // corners
                run_pair('0, WIDTH'(32'h1234_5678));
                run_pair(MIN_NEG, '0);
                run_pair(ALL_ONE, ALL_ONE);
                run_pair(MIN_NEG, WIDTH'(1));
                run_pair(MIN_NEG, MIN_NEG);             // 2^(2W-2)
                run_pair(MAX_POS, MIN_NEG);
                run_pair(MAX_POS, MAX_POS);

                for (int i = 0; i < N_RANDOM; i++)
                begin
                        draw_bits(WIDTH, bits);
                        a = bits[WIDTH-1:0];
                        draw_bits(WIDTH, bits);
                        b = bits[WIDTH-1:0];
                        a[WIDTH-1] = i[0];              // walk all four sign pairs
                        b[WIDTH-1] = i[1];
                        run_pair(a, b);
                end

                $display("TEST PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== verilog/imul_ctrl.sv ====
/*
 * iterative multiplier control: valid/ready fsm, iteration counter,
 * datapath opcode sequencing
 */
`default_nettype none

module imul_ctrl
#(
        parameter int WIDTH = imul_pkg::IMUL_WIDTH
)
(
        input  logic                    clk,
        input  logic                    reset,

        // request handshake
        input  logic                    req_val_i,
        output logic                    req_rdy_o,

        // response handshake
        input  logic                    resp_rdy_i,
        output logic                    resp_val_o,

        // datapath command
        output imul_pkg::dp_op_e        dp_op_o
);

        // counter must hold WIDTH itself
        localparam int CNT_W = $clog2(WIDTH + 1);
        localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(WIDTH);
        localparam logic [CNT_W-1:0] CNT_ONE  = CNT_W'(1);

        imul_pkg::imul_state_e  state;          // current fsm state
        imul_pkg::imul_state_e  state_nxt;
        logic [CNT_W-1:0]       iter_cnt;       // steps left including current one

        logic                   req_fire;       // request accepted this cycle
        logic                   resp_fire;      // response taken this cycle
        logic                   last_step;      // final RUN cycle

        // ------------------------------------------------------------------------
        // handshakes driven from state only
        // ------------------------------------------------------------------------
        assign req_rdy_o  = (state == imul_pkg::IDLE);
        assign resp_val_o = (state == imul_pkg::RESP);

        assign req_fire  = req_val_i && req_rdy_o;
        assign resp_fire = resp_rdy_i && resp_val_o;
        assign last_step = (state == imul_pkg::RUN) && (iter_cnt == CNT_ONE);

        // ------------------------------------------------------------------------
        // state register
        // ------------------------------------------------------------------------
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= imul_pkg::IDLE;
                end
                else
                begin
                        state <= state_nxt;
                end
        end

        // iteration counter loads on accept and counts down through RUN
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        iter_cnt <= '0;
                end
                else if (req_fire)
                begin
                        iter_cnt <= CNT_INIT;
                end
                else if (state == imul_pkg::RUN)
                begin
                        iter_cnt <= iter_cnt - CNT_ONE;
                end
        end

        // ------------------------------------------------------------------------
        // next state and datapath opcode
        // ------------------------------------------------------------------------
        always_comb
        begin
                state_nxt = state;
                dp_op_o   = imul_pkg::OP_HOLD;  // regs idle unless told otherwise

                case (state)
                        imul_pkg::IDLE:
                        begin
                                if (req_fire)
                                begin
                                        dp_op_o   = imul_pkg::OP_LOAD;  // capture this cycle
                                        state_nxt = imul_pkg::RUN;
                                end
                        end
                        imul_pkg::RUN:
                        begin
                                dp_op_o = imul_pkg::OP_STEP;    // one bit per cycle
                                if (last_step)
                                begin
                                        state_nxt = imul_pkg::RESP;
                                end
                        end
                        imul_pkg::RESP:
                        begin
                                if (resp_fire)
                                begin
                                        state_nxt = imul_pkg::IDLE;     // back to accepting
                                end
                        end
                        default:
                        begin
                                state_nxt = imul_pkg::IDLE;     // unused encoding
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== verilog/imul_dpath.sv ====
/*
 * iterative multiplier datapath: operand unsigning, shift-and-add
 * registers, sign capture and final re-signing of the product
 */
`default_nettype none

module imul_dpath
#(
        parameter int WIDTH = imul_pkg::IMUL_WIDTH
)
(
        input  logic                    clk,
        input  logic                    reset,

        // request operands, two's complement
        input  logic [WIDTH-1:0]        req_a_i,
        input  logic [WIDTH-1:0]        req_b_i,

        // command from ctrl
        input  imul_pkg::dp_op_e        dp_op_i,

        // signed product
        output logic [2*WIDTH-1:0]      resp_result_o
);

        localparam int PW = 2 * WIDTH;          // product width

        // ------------------------------------------------------------------------
        // operand unsigning
        // ------------------------------------------------------------------------
        logic                   a_neg;
        logic                   b_neg;
        logic [WIDTH-1:0]       a_mag;          // |a| where most negative maps to 2^(WIDTH-1)
        logic [WIDTH-1:0]       b_mag;

        assign a_neg = req_a_i[WIDTH-1];
        assign b_neg = req_b_i[WIDTH-1];

        assign a_mag = a_neg ? (~req_a_i + WIDTH'(1)) : req_a_i;
        assign b_mag = b_neg ? (~req_b_i + WIDTH'(1)) : req_b_i;

        // ------------------------------------------------------------------------
        // working registers
        // ------------------------------------------------------------------------
        logic [PW-1:0]          mcand_r;        // multiplicand, shifts left
        logic [WIDTH-1:0]       mplier_r;       // multiplier, shifts right
        logic [PW-1:0]          acc_r;          // running magnitude product
        logic                   sign_r;         // product is negative

        logic [PW-1:0]          addend;
        logic [PW-1:0]          acc_sum;

        // add only when current multiplier bit is set
        assign addend  = mplier_r[0] ? mcand_r : '0;
        assign acc_sum = acc_r + addend;

        // operand shift registers
        always_ff @(posedge clk)
        begin
                case (dp_op_i)
                        imul_pkg::OP_LOAD:
                        begin
                                mcand_r  <= {{WIDTH{1'b0}}, a_mag};     // zero-extend
                                mplier_r <= b_mag;
                        end
                        imul_pkg::OP_STEP:
                        begin
                                mcand_r  <= mcand_r << 1;
                                mplier_r <= mplier_r >> 1;
                        end
                        default:
                        begin
                                mcand_r  <= mcand_r;    // hold
                                mplier_r <= mplier_r;
                        end
                endcase
        end

        // accumulator and product sign
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        acc_r  <= '0;
                        sign_r <= 1'b0;
                end
                else
                begin
                        case (dp_op_i)
                                imul_pkg::OP_LOAD:
                                begin
                                        acc_r  <= '0;
                                        sign_r <= a_neg ^ b_neg;        // result sign
                                end
                                imul_pkg::OP_STEP:
                                begin
                                        acc_r  <= acc_sum;
                                end
                                default:
                                begin
                                        acc_r  <= acc_r;
                                        sign_r <= sign_r;
                                end
                        endcase
                end
        end

        // ------------------------------------------------------------------------
        // re-signing
        // ------------------------------------------------------------------------
        // valid only while ctrl holds resp_val_o
        assign resp_result_o = sign_r ? (~acc_r + PW'(1)) : acc_r;

endmodule

`default_nettype wire

// ==== verilog/imul_iterative.sv ====
/*
 * iterative signed multiplier top: control fsm plus shift-and-add datapath
 */
`default_nettype none

module imul_iterative
#(
        parameter int WIDTH = imul_pkg::IMUL_WIDTH     // operand width
)
(
        input  logic                    clk,
        input  logic                    reset,

        // request, valid/ready
        input  logic [WIDTH-1:0]        req_a_i,        // multiplicand
        input  logic [WIDTH-1:0]        req_b_i,        // multiplier
        input  logic                    req_val_i,
        output logic                    req_rdy_o,

        // response, valid/ready
        output logic [2*WIDTH-1:0]      resp_result_o,  // full signed product
        output logic                    resp_val_o,
        input  logic                    resp_rdy_i
);

        // ------------------------------------------------------------------------
        // ctrl to datapath
        // ------------------------------------------------------------------------
        imul_pkg::dp_op_e       dp_op;          // per-cycle datapath command

        // ------------------------------------------------------------------------
        // control owns handshakes and iteration count
        // ------------------------------------------------------------------------
        imul_ctrl
        #(
                .WIDTH          (WIDTH)
        )
        u_ctrl
        (
                .clk            (clk),
                .reset          (reset),
                .req_val_i      (req_val_i),
                .req_rdy_o      (req_rdy_o),
                .resp_rdy_i     (resp_rdy_i),
                .resp_val_o     (resp_val_o),
                .dp_op_o        (dp_op)
        );

        // ------------------------------------------------------------------------
        // datapath takes operands straight in and drives the product out
        // ------------------------------------------------------------------------
        imul_dpath
        #(
                .WIDTH          (WIDTH)
        )
        u_dpath
        (
                .clk            (clk),
                .reset          (reset),
                .req_a_i        (req_a_i),
                .req_b_i        (req_b_i),
                .dp_op_i        (dp_op),
                .resp_result_o  (resp_result_o)
        );

endmodule

`default_nettype wire

// ==== verilog/imul_pkg.sv ====
/*
 * shared multiplier definitions: default width, fsm states, datapath opcodes
 */
`default_nettype none

package imul_pkg;

        // ------------------------------------------------------------------------
        // widths
        // ------------------------------------------------------------------------
        parameter int IMUL_WIDTH = 32;          // default operand width

        // ------------------------------------------------------------------------
        // control fsm
        // ------------------------------------------------------------------------
        typedef enum logic [1:0] {
                IDLE = 2'd0,                    // waiting for a request
                RUN  = 2'd1,                    // shift-and-add iterations
                RESP = 2'd2                     // result presented downstream
        } imul_state_e;

        // ------------------------------------------------------------------------
        // datapath opcode issued by ctrl each cycle
        // ------------------------------------------------------------------------
        typedef enum logic [1:0] {
                OP_HOLD = 2'd0,                 // keep all regs
                OP_LOAD = 2'd1,                 // unsign operands, clear acc, latch sign
                OP_STEP = 2'd2                  // cond add, then shift both operands
        } dp_op_e;

endpackage

`default_nettype wire
